//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - source/rv_pkg.sv
      - source/instr_decoder.sv
      - source/reg_file.sv
      - source/alu.sv
      - source/load_store_unit.sv
      - source/core_control.sv
      - source/rv_core_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/rv_core_tb.sv

//--- sim.f
+incdir+verification
source/rv_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu.sv
source/load_store_unit.sv
source/core_control.sv
source/rv_core_top.sv
verification/rv_core_tb.sv

//--- source/alu.sv
`timescale 1ns/10ps

module alu (
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::word_t     imm_i,
    input  logic [2:0]        funct3,
    input  logic              funct7_alt,
    input  logic              is_arith_reg,
    input  logic              is_arith_imm,
    input  logic              is_branch,
    input  rv_pkg::reg_addr_t shamt,
    output rv_pkg::word_t     alu_result,
    output logic              branch_taken
);
    import rv_pkg::*;

    word_t      operand_b;
    word_t      diff;
    logic       borrow;
    logic       zero;
    logic       overflow;
    logic       less_signed;
    logic [4:0] shift_amount;

    assign operand_b = (is_arith_reg || is_branch) ? rs2_data : imm_i;

    // One subtractor feeds SUB, SLT, SLTU and every branch condition
    assign {borrow, diff} = {1'b0, rs1_data} - {1'b0, operand_b};
    assign zero        = (diff == '0);
    assign overflow    = (rs1_data[31] != operand_b[31]) && (diff[31] != rs1_data[31]);
    assign less_signed = diff[31] ^ overflow;

    assign shift_amount = is_arith_imm ? shamt : rs2_data[4:0];

    always_comb begin
        alu_result = '0;
        case (funct3_arith_t'(funct3))
            F3_ADD_SUB: begin
                // Only the register form has a subtract
                if (is_arith_reg && funct7_alt) begin
                    alu_result = diff;
                end else begin
                    alu_result = rs1_data + operand_b;
                end
            end
            F3_SLL:  alu_result = rs1_data << shift_amount;
            F3_SLT:  alu_result = word_t'(less_signed);
            F3_SLTU: alu_result = word_t'(borrow);
            F3_XOR:  alu_result = rs1_data ^ operand_b;
            F3_OR:   alu_result = rs1_data | operand_b;
            F3_AND:  alu_result = rs1_data & operand_b;
            F3_SRL_SRA: begin
                if (funct7_alt) begin
                    alu_result = $signed(rs1_data) >>> shift_amount;
                end else begin
                    alu_result = rs1_data >> shift_amount;
                end
            end
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        branch_taken = 1'b0;
        if (is_branch) begin
            case (funct3_branch_t'(funct3))
                F3_BEQ:  branch_taken = zero;
                F3_BNE:  branch_taken = !zero;
                F3_BLT:  branch_taken = less_signed;
                F3_BGE:  branch_taken = !less_signed;
                F3_BLTU: branch_taken = borrow;
                F3_BGEU: branch_taken = !borrow;
                default: branch_taken = 1'b0;
            endcase
        end
    end

endmodule

//--- source/core_control.sv
`timescale 1ns/10ps

module core_control #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic               clk_in,
    input  logic               reset_in,
    input  logic               mem_busy,
    input  logic               is_arith_reg,
    input  logic               is_arith_imm,
    input  logic               is_branch,
    input  logic               is_jal,
    input  logic               is_jalr,
    input  logic               is_lui,
    input  logic               is_auipc,
    input  logic               is_load,
    input  logic               is_store,
    input  logic               branch_taken,
    input  rv_pkg::word_t      alu_result,
    input  rv_pkg::word_t      load_result,
    input  rv_pkg::word_t      data_addr,
    input  rv_pkg::word_t      rs1_data,
    input  rv_pkg::word_t      imm_i,
    input  rv_pkg::word_t      imm_u,
    input  rv_pkg::word_t      imm_j,
    input  rv_pkg::word_t      imm_b,
    input  rv_pkg::word_t      store_wdata,
    input  rv_pkg::byte_mask_t store_wmask,
    output logic               fetch_done,
    output logic               wb_enable,
    output rv_pkg::word_t      wb_value,
    output rv_pkg::mem_cmd_t   mem_cmd,
    output rv_pkg::word_t      mem_addr,
    output rv_pkg::word_t      mem_wdata,
    output rv_pkg::byte_mask_t mem_wmask
);
    import rv_pkg::*;

    cpu_state_t state;
    word_t      pc;
    word_t      pc_next;
    // Low for the cycles in reset, holds off the first fetch command
    logic       running;
    logic       writes_rd;

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            state   <= ST_FETCH;
            pc      <= RESET_PC;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            case (state)
                ST_FETCH: begin
                    if (running) begin
                        state <= ST_WAIT_FETCH;
                    end
                end
                ST_WAIT_FETCH: begin
                    if (!mem_busy) begin
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    pc    <= pc_next;
                    state <= (is_load || is_store) ? ST_WAIT_MEM : ST_FETCH;
                end
                ST_WAIT_MEM: begin
                    if (!mem_busy) begin
                        state <= ST_FETCH;
                    end
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    assign fetch_done = (state == ST_WAIT_FETCH) && !mem_busy;

    always_comb begin
        pc_next = pc + 32'd4;
        if (is_jal) begin
            pc_next = pc + imm_j;
        end else if (is_jalr) begin
            pc_next = (rs1_data + imm_i) & ~32'd1;
        end else if (is_branch && branch_taken) begin
            pc_next = pc + imm_b;
        end
    end

    // Branches, stores and unknown opcodes leave writes_rd low
    always_comb begin
        wb_value  = '0;
        writes_rd = 1'b1;
        if (is_arith_reg || is_arith_imm) begin
            wb_value = alu_result;
        end else if (is_lui) begin
            wb_value = imm_u;
        end else if (is_auipc) begin
            wb_value = pc + imm_u;
        end else if (is_jal || is_jalr) begin
            wb_value = pc + 32'd4;
        end else if (is_load) begin
            wb_value = load_result;
        end else begin
            writes_rd = 1'b0;
        end
    end

    // Loads write once the data is back, everything else at the end of execute
    assign wb_enable = writes_rd &&
        (is_load ? ((state == ST_WAIT_MEM) && !mem_busy) : (state == ST_EXECUTE));

    always_comb begin
        mem_cmd = MEM_CMD_NONE;
        if ((state == ST_FETCH) && running) begin
            mem_cmd = MEM_CMD_LOAD;
        end else if ((state == ST_EXECUTE) && is_load) begin
            mem_cmd = MEM_CMD_LOAD;
        end else if ((state == ST_EXECUTE) && is_store) begin
            mem_cmd = MEM_CMD_STORE;
        end
    end

    assign mem_addr  = (state == ST_FETCH) ? pc : data_addr;
    assign mem_wdata = store_wdata;
    // Full mask for every load, instruction fetches included
    assign mem_wmask = ((state != ST_FETCH) && is_store) ? store_wmask : 4'b1111;

endmodule

//--- source/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  logic              clk_in,
    input  logic              reset_in,
    input  logic              fetch_done,
    input  rv_pkg::word_t     fetch_word,
    output rv_pkg::opcode_t   opcode,
    output logic [2:0]        funct3,
    output logic              funct7_alt,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::reg_addr_t shamt,
    output logic              is_arith_reg,
    output logic              is_arith_imm,
    output logic              is_branch,
    output logic              is_jal,
    output logic              is_jalr,
    output logic              is_lui,
    output logic              is_auipc,
    output logic              is_load,
    output logic              is_store,
    output rv_pkg::word_t     imm_i,
    output rv_pkg::word_t     imm_s,
    output rv_pkg::word_t     imm_b,
    output rv_pkg::word_t     imm_u,
    output rv_pkg::word_t     imm_j
);
    import rv_pkg::*;

    word_t instr;

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            instr <= '0;
        end else if (fetch_done) begin
            instr <= fetch_word;
        end
    end

    // An unknown opcode matches none of the class flags below
    assign opcode     = opcode_t'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7_alt = (instr[31:25] == FUNCT7_ALT);
    assign rd         = instr[11:7];
    assign shamt      = instr[24:20];

    assign is_arith_reg = (opcode == OPC_ARITH_R);
    assign is_arith_imm = (opcode == OPC_ARITH_I);
    assign is_branch    = (opcode == OPC_BRANCH);
    assign is_jal       = (opcode == OPC_JAL);
    assign is_jalr      = (opcode == OPC_JALR);
    assign is_lui       = (opcode == OPC_LUI);
    assign is_auipc     = (opcode == OPC_AUIPC);
    assign is_load      = (opcode == OPC_LOAD);
    assign is_store     = (opcode == OPC_STORE);

    // All immediates take their sign from bit 31
    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

//--- source/load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit (
    input  rv_pkg::word_t      rs1_data,
    input  rv_pkg::word_t      rs2_data,
    input  rv_pkg::word_t      imm_i,
    input  rv_pkg::word_t      imm_s,
    input  logic [2:0]         funct3,
    input  logic               is_load,
    input  logic               is_store,
    input  rv_pkg::word_t      mem_rdata,
    output rv_pkg::word_t      data_addr,
    output rv_pkg::word_t      store_wdata,
    output rv_pkg::byte_mask_t store_wmask,
    output rv_pkg::word_t      load_result
);
    import rv_pkg::*;

    word_t      byte_addr;
    logic [1:0] byte_offset;
    mem_size_t  size;
    word_t      lane_word;
    logic       sign_ext;

    assign byte_addr   = rs1_data + (is_store ? imm_s : imm_i);
    assign byte_offset = byte_addr[1:0];
    assign data_addr   = {byte_addr[31:2], 2'b00};
    assign size        = mem_size_t'(funct3[1:0]);
    assign sign_ext    = !funct3[2];

    // Addressed lane moved down to bit 0
    assign lane_word = mem_rdata >> {byte_offset, 3'b000};

    always_comb begin
        store_wdata = '0;
        store_wmask = '0;
        if (is_store) begin
            case (size)
                MEM_BYTE: begin
                    store_wdata = word_t'(rs2_data[7:0]) << {byte_offset, 3'b000};
                    store_wmask = 4'b0001 << byte_offset;
                end
                MEM_HALF: begin
                    store_wdata = word_t'(rs2_data[15:0]) << {byte_offset[1], 4'b0000};
                    store_wmask = byte_offset[1] ? 4'b1100 : 4'b0011;
                end
                MEM_WORD: begin
                    store_wdata = rs2_data;
                    store_wmask = 4'b1111;
                end
                default: begin
                    store_wdata = '0;
                    store_wmask = '0;
                end
            endcase
        end
    end

    always_comb begin
        load_result = '0;
        if (is_load) begin
            case (size)
                MEM_BYTE: load_result = {{24{sign_ext & lane_word[7]}}, lane_word[7:0]};
                MEM_HALF: load_result = {{16{sign_ext & lane_word[15]}}, lane_word[15:0]};
                MEM_WORD: load_result = mem_rdata;
                default:  load_result = '0;
            endcase
        end
    end

endmodule

//--- source/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic              clk_in,
    input  logic              reset_in,
    input  logic              fetch_done,
    input  rv_pkg::word_t     fetch_word,
    input  logic              wb_enable,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     wb_value,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [32];

    // x0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable && (rd != '0)) begin
            regs[rd] <= wb_value;
        end
    end

    // Source indices come straight from the word arriving on the bus
    always_ff @(posedge clk_in) begin
        if (fetch_done) begin
            rs1_data <= regs[fetch_word[19:15]];
            rs2_data <= regs[fetch_word[24:20]];
        end
    end

endmodule

//--- source/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic               clk_in,
    input  logic               reset_in,
    output rv_pkg::mem_cmd_t   mem_cmd,
    output rv_pkg::word_t      mem_addr,
    output rv_pkg::word_t      mem_wdata,
    output rv_pkg::byte_mask_t mem_wmask,
    input  logic               mem_busy,
    input  rv_pkg::word_t      mem_rdata
);
    import rv_pkg::*;

    logic       fetch_done;
    logic       wb_enable;
    word_t      wb_value;

    logic [2:0] funct3;
    logic       funct7_alt;
    reg_addr_t  rd;
    reg_addr_t  shamt;
    logic       is_arith_reg;
    logic       is_arith_imm;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_lui;
    logic       is_auipc;
    logic       is_load;
    logic       is_store;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    word_t      rs1_data, rs2_data;
    word_t      alu_result;
    logic       branch_taken;
    word_t      data_addr, store_wdata, load_result;
    byte_mask_t store_wmask;

    // The raw opcode is only kept for debug visibility
    instr_decoder decoder_i (.fetch_word(mem_rdata), .opcode(), .*);

    reg_file reg_file_i (.fetch_word(mem_rdata), .*);

    alu alu_i (.*);

    load_store_unit lsu_i (.*);

    core_control #(.RESET_PC(RESET_PC)) control_i (.*);

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    // Bit 0 enables the lowest byte of the word
    typedef logic [3:0]  byte_mask_t;

    // Major opcodes handled by the core, anything else runs as a no-op
    typedef enum logic [6:0] {
        OPC_ARITH_R = 7'b0110011,
        OPC_ARITH_I = 7'b0010011,
        OPC_BRANCH  = 7'b1100011,
        OPC_JAL     = 7'b1101111,
        OPC_JALR    = 7'b1100111,
        OPC_LOAD    = 7'b0000011,
        OPC_STORE   = 7'b0100011,
        OPC_LUI     = 7'b0110111,
        OPC_AUIPC   = 7'b0010111
    } opcode_t;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_arith_t;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } funct3_branch_t;

    // Low two bits of funct3 for loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_t;

    typedef enum logic [1:0] {
        MEM_CMD_NONE  = 2'b00,
        MEM_CMD_LOAD  = 2'b01,
        MEM_CMD_STORE = 2'b10
    } mem_cmd_t;

    typedef enum logic [3:0] {
        ST_FETCH      = 4'b0001,
        ST_WAIT_FETCH = 4'b0010,
        ST_EXECUTE    = 4'b0100,
        ST_WAIT_MEM   = 4'b1000
    } cpu_state_t;

    // Selects SUB over ADD and SRA over SRL
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

//--- verification/tb_program.svh
// x1 = -8 and x2 = 0x35 are the ALU operands, x10 points at the store area,
// x11 at the preset load words
task automatic load_program();
    prog_len = 0;
    emit(enc_i(512, 0, 0, 10, OP_IMM));
    emit(enc_i(768, 0, 0, 11, OP_IMM));
    emit(enc_i(-8, 0, 0, 1, OP_IMM));
    emit(enc_i(53, 0, 0, 2, OP_IMM));

    // Register forms: add, sub, and, or, xor, slt, sltu, sll, srl, sra
    op_then_store(enc_r(7'h00, 2, 1, 0, 3), 0);
    op_then_store(enc_r(7'h20, 2, 1, 0, 3), 4);
    op_then_store(enc_r(7'h00, 2, 1, 7, 3), 8);
    op_then_store(enc_r(7'h00, 2, 1, 6, 3), 12);
    op_then_store(enc_r(7'h00, 2, 1, 4, 3), 16);
    op_then_store(enc_r(7'h00, 2, 1, 2, 3), 20);
    op_then_store(enc_r(7'h00, 2, 1, 3, 3), 24);
    op_then_store(enc_r(7'h00, 2, 1, 1, 3), 28);
    op_then_store(enc_r(7'h00, 2, 1, 5, 3), 32);
    op_then_store(enc_r(7'h20, 2, 1, 5, 3), 36);

    // Immediate forms: slli, srli, srai, slti, sltiu, xori, andi, ori
    op_then_store(enc_i(4, 1, 1, 3, OP_IMM), 40);
    op_then_store(enc_i(28, 1, 5, 3, OP_IMM), 44);
    op_then_store(enc_i(12'h402, 1, 5, 3, OP_IMM), 48);
    op_then_store(enc_i(-7, 1, 2, 3, OP_IMM), 52);
    op_then_store(enc_i(5, 1, 3, 3, OP_IMM), 56);
    op_then_store(enc_i(12'h0F0, 1, 4, 3, OP_IMM), 60);
    op_then_store(enc_i(12'h70C, 2, 7, 3, OP_IMM), 64);
    op_then_store(enc_i(-256, 2, 6, 3, OP_IMM), 68);

    // x5 = 0x89ABCDEF, then LUI alone and AUIPC at address 0xF4
    emit(enc_u(20'h89ABD, 5, OP_LUI));
    emit(enc_i(-529, 5, 0, 5, OP_IMM));
    emit(enc_s(72, 5, 10, 2));
    emit(enc_u(20'hFEDCB, 6, OP_LUI));
    emit(enc_s(76, 6, 10, 2));
    emit(enc_u(20'h00012, 7, OP_AUIPC));
    emit(enc_s(80, 7, 10, 2));

    // Byte stores at every lane, half-word stores at both halves
    emit(enc_s(84, 5, 10, 0));
    emit(enc_s(89, 5, 10, 0));
    emit(enc_s(94, 5, 10, 0));
    emit(enc_s(99, 5, 10, 0));
    emit(enc_s(100, 5, 10, 1));
    emit(enc_s(106, 5, 10, 1));

    // A write to x0 is dropped
    emit(enc_i(12'h055, 5, 0, 0, OP_IMM));
    emit(enc_s(108, 0, 10, 2));

    // Loads: lb at lanes 0 to 3, lbu, lh, lhu and lw
    op_then_store(enc_i(0, 11, 0, 3, OP_LOAD), 112);
    op_then_store(enc_i(1, 11, 0, 3, OP_LOAD), 116);
    op_then_store(enc_i(2, 11, 0, 3, OP_LOAD), 120);
    op_then_store(enc_i(3, 11, 0, 3, OP_LOAD), 124);
    op_then_store(enc_i(4, 11, 4, 3, OP_LOAD), 128);
    op_then_store(enc_i(2, 11, 4, 3, OP_LOAD), 132);
    op_then_store(enc_i(0, 11, 1, 3, OP_LOAD), 136);
    op_then_store(enc_i(4, 11, 1, 3, OP_LOAD), 140);
    op_then_store(enc_i(2, 11, 5, 3, OP_LOAD), 144);
    op_then_store(enc_i(4, 11, 2, 3, OP_LOAD), 148);

    // beq, bne, blt, bge, bltu, bgeu
    branch_pair(0, 1, 2, 1, 1, 152);
    branch_pair(1, 1, 1, 1, 2, 156);
    branch_pair(4, 2, 1, 1, 2, 160);
    branch_pair(5, 1, 2, 2, 1, 164);
    branch_pair(6, 1, 2, 2, 1, 168);
    branch_pair(7, 2, 1, 1, 2, 172);

    // JAL at 0x1CC over one bad store, JALR from 0x1DC to 0x1E8
    emit(enc_j(8, 8));
    emit(enc_s(0, 1, 10, 2));
    emit(enc_s(176, 8, 10, 2));
    emit(enc_i(12'h1E9, 0, 0, 9, OP_IMM));
    emit(enc_i(0, 9, 0, 12, OP_JALR));
    emit(enc_s(0, 1, 10, 2));
    emit(enc_s(0, 1, 10, 2));
    emit(enc_s(180, 12, 10, 2));
    emit(enc_j(0, 0));

    // Preset load words at 0x300 and 0x304
    mem[192] = 32'h83F4_7105;
    mem[193] = 32'h7F0E_92C8;

    expect_store(32'h200, 32'h0000_002D, 4'hF);
    expect_store(32'h204, 32'hFFFF_FFC3, 4'hF);
    expect_store(32'h208, 32'h0000_0030, 4'hF);
    expect_store(32'h20C, 32'hFFFF_FFFD, 4'hF);
    expect_store(32'h210, 32'hFFFF_FFCD, 4'hF);
    expect_store(32'h214, 32'h0000_0001, 4'hF);
    expect_store(32'h218, 32'h0000_0000, 4'hF);
    expect_store(32'h21C, 32'hFF00_0000, 4'hF);
    expect_store(32'h220, 32'h0000_07FF, 4'hF);
    expect_store(32'h224, 32'hFFFF_FFFF, 4'hF);
    expect_store(32'h228, 32'hFFFF_FF80, 4'hF);
    expect_store(32'h22C, 32'h0000_000F, 4'hF);
    expect_store(32'h230, 32'hFFFF_FFFE, 4'hF);
    expect_store(32'h234, 32'h0000_0001, 4'hF);
    expect_store(32'h238, 32'h0000_0000, 4'hF);
    expect_store(32'h23C, 32'hFFFF_FF08, 4'hF);
    expect_store(32'h240, 32'h0000_0004, 4'hF);
    expect_store(32'h244, 32'hFFFF_FF35, 4'hF);
    expect_store(32'h248, 32'h89AB_CDEF, 4'hF);
    expect_store(32'h24C, 32'hFEDC_B000, 4'hF);
    expect_store(32'h250, 32'h0001_20F4, 4'hF);
    expect_store(32'h254, 32'h0000_00EF, 4'h1);
    expect_store(32'h258, 32'h0000_EF00, 4'h2);
    expect_store(32'h25C, 32'h00EF_0000, 4'h4);
    expect_store(32'h260, 32'hEF00_0000, 4'h8);
    expect_store(32'h264, 32'h0000_CDEF, 4'h3);
    expect_store(32'h268, 32'hCDEF_0000, 4'hC);
    expect_store(32'h26C, 32'h0000_0000, 4'hF);
    expect_store(32'h270, 32'h0000_0005, 4'hF);
    expect_store(32'h274, 32'h0000_0071, 4'hF);
    expect_store(32'h278, 32'hFFFF_FFF4, 4'hF);
    expect_store(32'h27C, 32'hFFFF_FF83, 4'hF);
    expect_store(32'h280, 32'h0000_00C8, 4'hF);
    expect_store(32'h284, 32'h0000_00F4, 4'hF);
    expect_store(32'h288, 32'h0000_7105, 4'hF);
    expect_store(32'h28C, 32'hFFFF_92C8, 4'hF);
    expect_store(32'h290, 32'h0000_83F4, 4'hF);
    expect_store(32'h294, 32'h7F0E_92C8, 4'hF);
    expect_store(32'h298, 32'h0000_0035, 4'hF);
    expect_store(32'h29C, 32'h0000_0035, 4'hF);
    expect_store(32'h2A0, 32'h0000_0035, 4'hF);
    expect_store(32'h2A4, 32'h0000_0035, 4'hF);
    expect_store(32'h2A8, 32'h0000_0035, 4'hF);
    expect_store(32'h2AC, 32'h0000_0035, 4'hF);
    expect_store(32'h2B0, 32'h0000_01D0, 4'hF);
    expect_store(32'h2B4, 32'h0000_01E0, 4'hF);
endtask

//--- verification/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;
    import rv_pkg::*;

    localparam word_t      RESET_PC      = 32'h0000_0040;
    localparam int         MEM_WORDS     = 256;
    localparam int         CMD_TIMEOUT   = 50;
    localparam int         MAX_COMMANDS  = 2000;
    // Commands served after the last expected store, so stray stores still show up
    localparam int         TAIL_COMMANDS = 20;
    localparam logic [6:0] OP_IMM        = 7'h13;
    localparam logic [6:0] OP_LOAD       = 7'h03;
    localparam logic [6:0] OP_JALR       = 7'h67;
    localparam logic [6:0] OP_LUI        = 7'h37;
    localparam logic [6:0] OP_AUIPC      = 7'h17;

    logic       clk_in;
    logic       reset_in;
    mem_cmd_t   mem_cmd;
    word_t      mem_addr;
    word_t      mem_wdata;
    byte_mask_t mem_wmask;
    logic       mem_busy;
    word_t      mem_rdata;

    word_t       mem [MEM_WORDS];
    int          prog_len;
    logic [31:0] rng_state;
    word_t       exp_addr [$];
    word_t       exp_data [$];
    byte_mask_t  exp_mask [$];
    int          stores_seen;
    int          served;
    int          tail;

    rv_core_top #(.RESET_PC(RESET_PC)) dut_i (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .mem_cmd  (mem_cmd),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_wmask(mem_wmask),
        .mem_busy (mem_busy),
        .mem_rdata(mem_rdata)
    );

    always #10 clk_in = ~clk_in;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // RV32I instruction encoders
    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] opc);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1, int f3);
        logic [11:0] s;
        s = 12'(imm);
        return {s[11:5], 5'(rs2), 5'(rs1), 3'(f3), s[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        logic [12:0] b;
        b = 13'(imm);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'(f3), b[4:1], b[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(int imm20, int rd, logic [6:0] opc);
        return {20'(imm20), 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        logic [20:0] j;
        j = 21'(imm);
        return {j[20], j[10:1], j[11], j[19:12], 5'(rd), 7'h6F};
    endfunction

    // The program is laid out from the reset address on
    task automatic emit(input logic [31:0] instr);
        mem[RESET_PC / 4 + prog_len] = instr;
        prog_len++;
    endtask

    // Result lands in x3, stored at an offset from x10
    task automatic op_then_store(input logic [31:0] instr, input int offset);
        emit(instr);
        emit(enc_s(offset, 3, 10, 2));
    endtask

    // A not-taken branch in front of a good store, then a taken one over a bad store
    task automatic branch_pair(input int f3, input int nt_rs1, input int nt_rs2,
                               input int t_rs1, input int t_rs2, input int offset);
        emit(enc_b(8, nt_rs2, nt_rs1, f3));
        emit(enc_s(offset, 2, 10, 2));
        emit(enc_b(8, t_rs2, t_rs1, f3));
        emit(enc_s(0, 1, 10, 2));
    endtask

    task automatic expect_store(input word_t addr, input word_t data, input byte_mask_t mask);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_mask.push_back(mask);
    endtask

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, got, expected);
            stop_with_failure();
        end
    endtask

    `include "tb_program.svh"

    // Waits for one command, holds busy for a random time, then completes it
    task automatic serve_command();
        mem_cmd_t   cmd;
        word_t      addr;
        word_t      wdata;
        byte_mask_t wmask;
        int         extra;
        int         waited;
        int         idx;
        waited = 0;
        while (mem_cmd == MEM_CMD_NONE) begin
            if (waited == CMD_TIMEOUT) begin
                $display("Timeout: no memory command from the core in %0d cycles", waited);
                stop_with_failure();
            end
            @(negedge clk_in);
            waited++;
        end
        cmd   = mem_cmd;
        addr  = mem_addr;
        wdata = mem_wdata;
        wmask = mem_wmask;
        check_value("mem_addr[1:0]", addr[1:0], 2'b00);
        if (addr >= MEM_WORDS * 4) begin
            $display("Memory access outside the model at address %h", addr);
            stop_with_failure();
        end
        idx      = addr[31:2];
        mem_busy = 1'b1;
        extra    = next_random() % 4;
        @(negedge clk_in);
        repeat (extra) @(negedge clk_in);
        if (cmd == MEM_CMD_LOAD) begin
            check_value("mem_wmask", wmask, 4'hF);
            mem_rdata = mem[idx];
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            if (stores_seen >= exp_addr.size()) begin
                $display("Unexpected store to address %h", addr);
                stop_with_failure();
            end
            check_value("mem_addr", addr, exp_addr[stores_seen]);
            check_value("mem_wdata", wdata, exp_data[stores_seen]);
            check_value("mem_wmask", wmask, exp_mask[stores_seen]);
            stores_seen++;
        end
        mem_busy = 1'b0;
        @(negedge clk_in);
    endtask

    initial begin
        clk_in      = 1'b0;
        reset_in    = 1'b0;
        mem_busy    = 1'b0;
        mem_rdata   = '0;
        rng_state   = 32'd61021;
        stores_seen = 0;
        served      = 0;
        tail        = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hA5C3_0000 ^ 32'(i * 4);
        end
        load_program();

        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        check_value("mem_cmd", mem_cmd, MEM_CMD_NONE);
        reset_in = 1'b1;
        @(negedge clk_in);
        check_value("mem_cmd", mem_cmd, MEM_CMD_LOAD);
        check_value("mem_addr", mem_addr, RESET_PC);

        while (tail < TAIL_COMMANDS) begin
            if (served == MAX_COMMANDS) begin
                $display("Timeout: only %0d of %0d stores seen", stores_seen, exp_addr.size());
                stop_with_failure();
            end
            serve_command();
            served++;
            if (stores_seen == exp_addr.size()) begin
                tail++;
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule
